/* common/cp_defines.svh */
`ifndef CP_DEFINES_SVH
`define CP_DEFINES_SVH

// Thread geometry of the barrel
`define CP_THREAD_COUNT         8
`define CP_THREAD_ADDR_WIDTH    3

// Program counter and instruction memory
`define CP_PC_WIDTH             10
`define CP_I_DEPTH              1024

// ALU word and instruction fields
`define CP_WORD_WIDTH           36
`define CP_D_WIDTH              12
`define CP_OPCODE_WIDTH         4
`define CP_AB_ADDR_WIDTH        10

// Write address windows
`define CP_I_WRITE_BASE         12'h000
`define CP_BRANCH_WRITE_BASE    12'h800

// Branch tables with entries indexed as {thread, slot}
`define CP_BRANCH_COUNT         2
`define CP_BT_DEPTH             (`CP_THREAD_COUNT * `CP_BRANCH_COUNT)
`define CP_BT_INDEX_WIDTH       4

// Pipeline depths
`define CP_I_TAP_DEPTH          1
`define CP_AB_READ_DEPTH        2

`endif

/* common/cp_isa_pkg.sv */
`include "cp_defines.svh"

package cp_isa_pkg;

    // Instruction word as stored in instruction memory
    typedef struct packed {
        logic [`CP_OPCODE_WIDTH-1:0]    opcode;
        logic [`CP_D_WIDTH-1:0]         d;
        logic [`CP_AB_ADDR_WIDTH-1:0]   a;
        logic [`CP_AB_ADDR_WIDTH-1:0]   b;
    } cp_instr_t;

    // Branch conditions tested on the previous ALU result as a signed number
    typedef enum logic [2:0] {
        COND_ALWAYS     = 3'd0,
        COND_NEVER      = 3'd1,
        COND_ZERO       = 3'd2,
        COND_NONZERO    = 3'd3,
        COND_NEGATIVE   = 3'd4,
        COND_POSITIVE   = 3'd5
    } cp_cond_e;

    // One branch table entry padded out to a full ALU word
    typedef struct packed {
        logic                       enable;
        logic                       cancel_on_taken;
        cp_cond_e                   condition;
        logic [`CP_PC_WIDTH-1:0]    origin;
        logic [`CP_PC_WIDTH-1:0]    destination;
        logic [10:0]                reserved;
    } cp_branch_entry_t;

    // The same ALU word is an instruction in one window and a branch entry in the other
    typedef union packed {
        cp_instr_t                  instr;
        cp_branch_entry_t           branch;
        logic [`CP_WORD_WIDTH-1:0]  raw;
    } cp_alu_word_u;

endpackage

/* common/cp_thread_pkg.sv */
`include "cp_defines.svh"

package cp_thread_pkg;

    import cp_isa_pkg::*;

    typedef logic [`CP_THREAD_ADDR_WIDTH-1:0] cp_thread_t;
    typedef logic [`CP_PC_WIDTH-1:0]          cp_pc_t;

    // Names the thread and PC of the instruction at the same pipeline stage
    typedef struct packed {
        logic       valid;
        cp_thread_t thread;
        cp_pc_t     pc;
    } cp_fetch_t;

    // ALU write port whose data doubles as the previous ALU result
    typedef struct packed {
        logic                       en;
        logic [`CP_D_WIDTH-1:0]     addr;
        cp_alu_word_u               data;
    } cp_alu_write_t;

endpackage

/* design/write_port_decoder.sv */
`timescale 1ns/100ps
`include "cp_defines.svh"

module write_port_decoder
    import cp_isa_pkg::*;
    import cp_thread_pkg::*;
(
    input  logic                            clock,
    input  logic                            rst_n,
    input  cp_alu_write_t                   alu_write,
    output logic                            i_wr_en,
    output cp_pc_t                          i_wr_addr,
    output cp_instr_t                       i_wr_word,
    output logic                            bt_wr_en,
    output logic [`CP_BT_INDEX_WIDTH-1:0]   bt_wr_index,
    output cp_branch_entry_t                bt_wr_entry
);

    localparam logic [`CP_D_WIDTH-1:0] I_SPAN  = `CP_I_DEPTH;
    localparam logic [`CP_D_WIDTH-1:0] BT_SPAN = `CP_BT_DEPTH;

    logic [`CP_D_WIDTH-1:0] i_offset;
    logic [`CP_D_WIDTH-1:0] bt_offset;
    logic                   i_hit;
    logic                   bt_hit;

    // Offsets below a base wrap to large values, so one compare covers both window edges
    assign i_offset  = alu_write.addr - `CP_I_WRITE_BASE;
    assign bt_offset = alu_write.addr - `CP_BRANCH_WRITE_BASE;

    assign i_hit  = alu_write.en && (i_offset < I_SPAN);
    assign bt_hit = alu_write.en && (bt_offset < BT_SPAN);

    // The write port is taken in on the edge and handed to the memories one cycle on
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            i_wr_en  <= 1'b0;
            bt_wr_en <= 1'b0;
        end else begin
            i_wr_en  <= i_hit;
            bt_wr_en <= bt_hit;
        end
    end

    always_ff @(posedge clock) begin
        i_wr_addr   <= i_offset[`CP_PC_WIDTH-1:0];
        i_wr_word   <= alu_write.data.instr;        // Instruction view of the word
        bt_wr_index <= bt_offset[`CP_BT_INDEX_WIDTH-1:0];
        bt_wr_entry <= alu_write.data.branch;       // Branch view of the same word
    end

endmodule

/* design/instr_mem.sv */
`timescale 1ns/100ps
`include "cp_defines.svh"

module instr_mem
    import cp_isa_pkg::*;
    import cp_thread_pkg::*;
(
    input  logic        clock,
    input  logic        wr_en,
    input  cp_pc_t      wr_addr,
    input  cp_instr_t   wr_word,
    input  cp_pc_t      rd_addr,
    output cp_instr_t   rd_data
);

    cp_instr_t ram [`CP_I_DEPTH];
    cp_instr_t ram_q;
    cp_instr_t tap [`CP_I_TAP_DEPTH];

    // Simple dual port with a read that is always on

    always_ff @(posedge clock) begin
        if (wr_en) begin
            ram[wr_addr] <= wr_word;
        end
    end

    always_ff @(posedge clock) begin
        ram_q <= ram[rd_addr];  // Read before write on an address clash
    end

    // The tap stage should be retimed into the block RAM by synthesis.
    // Nothing may connect to ram_q directly, or the RAM output becomes the critical path
    always_ff @(posedge clock) begin
        tap[0] <= ram_q;
        for (int i = 1; i < `CP_I_TAP_DEPTH; i++) begin
            tap[i] <= tap[i-1];
        end
    end

    assign rd_data = tap[`CP_I_TAP_DEPTH-1];

endmodule

/* branch_folding/branch_folding.sv */
`timescale 1ns/100ps
`include "cp_defines.svh"

module branch_folding
    import cp_isa_pkg::*;
    import cp_thread_pkg::*;
(
    input  logic                            clock,
    input  logic                            rst_n,
    input  cp_fetch_t                       fetch,
    input  cp_alu_word_u                    r_prev,
    input  logic                            bt_wr_en,
    input  logic [`CP_BT_INDEX_WIDTH-1:0]   bt_wr_index,
    input  cp_branch_entry_t                bt_wr_entry,
    output logic                            jump,
    output cp_pc_t                          branch_destination,
    output logic                            cancel
);

    logic [`CP_BT_DEPTH-1:0]        bt_enable;
    cp_branch_entry_t               bt_entry [`CP_BT_DEPTH];
    logic [`CP_BT_INDEX_WIDTH-1:0]  idx0;
    logic [`CP_BT_INDEX_WIDTH-1:0]  idx1;
    cp_branch_entry_t               entry0;
    cp_branch_entry_t               entry1;
    logic                           hit0;
    logic                           hit1;
    cp_branch_entry_t               sel;
    logic                           cond_ok;

    // Test one condition against the previous result read as a signed number
    function automatic logic cond_true(
        input cp_cond_e                         cond,
        input logic signed [`CP_WORD_WIDTH-1:0] r
    );
        logic result;
        case (cond)
            COND_ALWAYS:   result = 1'b1;
            COND_NEVER:    result = 1'b0;
            COND_ZERO:     result = (r == '0);
            COND_NONZERO:  result = (r != '0);
            COND_NEGATIVE: result = (r < 0);
            COND_POSITIVE: result = (r > 0);
            default:       result = 1'b0;   // Unused encodings never fire
        endcase
        return result;
    endfunction

    // Enables are the only table state that reset touches
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            bt_enable <= '0;
        end else if (bt_wr_en) begin
            bt_enable[bt_wr_index] <= bt_wr_entry.enable;
        end
    end

    always_ff @(posedge clock) begin
        if (bt_wr_en) begin
            bt_entry[bt_wr_index] <= bt_wr_entry;
        end
    end

    // Each thread owns the two consecutive entries {thread, slot}
    assign idx0 = {fetch.thread, 1'b0};
    assign idx1 = {fetch.thread, 1'b1};

    assign entry0 = bt_entry[idx0];
    assign entry1 = bt_entry[idx1];

    assign hit0 = bt_enable[idx0] && (entry0.origin == fetch.pc);
    assign hit1 = bt_enable[idx1] && (entry1.origin == fetch.pc);

    // Slot 0 decides whenever it matches, even if its condition fails
    assign sel = hit0 ? entry0 : entry1;

    assign cond_ok = cond_true(sel.condition, signed'(r_prev.raw));

    assign jump               = fetch.valid && (hit0 || hit1) && cond_ok;
    assign branch_destination = sel.destination;
    assign cancel             = jump && sel.cancel_on_taken;

endmodule

/* design/thread_controller.sv */
`timescale 1ns/100ps
`include "cp_defines.svh"

module thread_controller
    import cp_thread_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        ready,
    input  logic        ready_jump,
    input  cp_pc_t      ready_destination,
    output cp_pc_t      issue_pc,
    output cp_fetch_t   fetch
);

    localparam cp_thread_t LAST_THREAD = cp_thread_t'(`CP_THREAD_COUNT - 1);
    localparam int         REC_DEPTH   = 2 + `CP_AB_READ_DEPTH;

    cp_thread_t thread_cnt;
    cp_pc_t     pc_mem [`CP_THREAD_COUNT];
    cp_fetch_t  issue;
    cp_fetch_t  rec [REC_DEPTH];
    cp_fetch_t  done;

    // Strict round robin, one thread per cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            thread_cnt <= '0;
        end else begin
            thread_cnt <= (thread_cnt == LAST_THREAD) ? '0 : thread_cnt + 1'b1;
        end
    end

    assign issue_pc     = pc_mem[thread_cnt];
    assign issue.valid  = 1'b1;
    assign issue.thread = thread_cnt;
    assign issue.pc     = issue_pc;

    // Stages 0 and 1 follow the RAM read and tap while the rest wait for the delayed retire
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REC_DEPTH; i++) begin
                rec[i] <= '0;
            end
        end else begin
            rec[0] <= issue;
            for (int i = 1; i < REC_DEPTH; i++) begin
                rec[i] <= rec[i-1];
            end
        end
    end

    assign fetch = rec[1];          // Lines up with the instruction leaving the tap
    assign done  = rec[REC_DEPTH-1];

    // With eight threads against a four cycle loop the write lands before the next issue
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CP_THREAD_COUNT; i++) begin
                pc_mem[i] <= '0;
            end
        end else if (done.valid) begin
            if (ready_jump) begin
                pc_mem[done.thread] <= ready_destination;
            end else if (ready) begin
                pc_mem[done.thread] <= done.pc + 1'b1;
            end
            // Neither one replays the same PC on the thread's next turn
        end
    end

endmodule

/* design/control_path.sv */
`timescale 1ns/100ps
`include "cp_defines.svh"

module control_path
    import cp_isa_pkg::*;
    import cp_thread_pkg::*;
(
    input  logic            clock,
    input  logic            rst_n,
    input  cp_alu_write_t   alu_write,
    input  logic            io_ready,
    output cp_instr_t       instr,
    output cp_fetch_t       fetch,
    output logic            cancel
);

    logic                               i_wr_en;
    cp_pc_t                             i_wr_addr;
    cp_instr_t                          i_wr_word;
    logic                               bt_wr_en;
    logic [`CP_BT_INDEX_WIDTH-1:0]      bt_wr_index;
    cp_branch_entry_t                   bt_wr_entry;
    cp_pc_t                             issue_pc;
    logic                               jump;
    cp_pc_t                             branch_destination;
    logic                               retire;
    logic [`CP_AB_READ_DEPTH-1:0]       retire_pipe;
    logic [`CP_AB_READ_DEPTH-1:0]       jump_pipe;
    cp_pc_t                             dest_pipe [`CP_AB_READ_DEPTH];

    write_port_decoder u_write_port_decoder (
        .clock          (clock),
        .rst_n          (rst_n),
        .alu_write      (alu_write),
        .i_wr_en        (i_wr_en),
        .i_wr_addr      (i_wr_addr),
        .i_wr_word      (i_wr_word),
        .bt_wr_en       (bt_wr_en),
        .bt_wr_index    (bt_wr_index),
        .bt_wr_entry    (bt_wr_entry)
    );

    instr_mem u_instr_mem (
        .clock          (clock),
        .wr_en          (i_wr_en),
        .wr_addr        (i_wr_addr),
        .wr_word        (i_wr_word),
        .rd_addr        (issue_pc),
        .rd_data        (instr)
    );

    branch_folding u_branch_folding (
        .clock              (clock),
        .rst_n              (rst_n),
        .fetch              (fetch),
        .r_prev             (alu_write.data),
        .bt_wr_en           (bt_wr_en),
        .bt_wr_index        (bt_wr_index),
        .bt_wr_entry        (bt_wr_entry),
        .jump               (jump),
        .branch_destination (branch_destination),
        .cancel             (cancel)
    );

    // A cancelled instruction is forced ready so its thread never re-issues it
    assign retire = io_ready | cancel;

    // Line retire and the branch outcome up with the A/B operand reads
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            retire_pipe <= '0;
            jump_pipe   <= '0;
        end else begin
            retire_pipe <= {retire_pipe[`CP_AB_READ_DEPTH-2:0], retire};
            jump_pipe   <= {jump_pipe[`CP_AB_READ_DEPTH-2:0], jump};
        end
    end

    always_ff @(posedge clock) begin
        dest_pipe[0] <= branch_destination;
        for (int i = 1; i < `CP_AB_READ_DEPTH; i++) begin
            dest_pipe[i] <= dest_pipe[i-1];
        end
    end

    thread_controller u_thread_controller (
        .clock              (clock),
        .rst_n              (rst_n),
        .ready              (retire_pipe[`CP_AB_READ_DEPTH-1]),
        .ready_jump         (jump_pipe[`CP_AB_READ_DEPTH-1]),
        .ready_destination  (dest_pipe[`CP_AB_READ_DEPTH-1]),
        .issue_pc           (issue_pc),
        .fetch              (fetch)
    );

endmodule

/* verif/cp_ref_model.svh */
`ifndef CP_REF_MODEL_SVH
`define CP_REF_MODEL_SVH

// One issued instruction, followed from issue until its PC update
typedef struct packed {
    logic       valid;
    cp_thread_t thread;
    cp_pc_t     pc;
    logic       known;
    cp_instr_t  word;
    logic       retire;
    logic       jump;
    cp_pc_t     dest;
} issue_rec_t;

cp_instr_t          m_imem [`CP_I_DEPTH];
logic               m_known [`CP_I_DEPTH];      // Low until the address has been written
cp_branch_entry_t   m_bt [`CP_BT_DEPTH];
cp_pc_t             m_pc [`CP_THREAD_COUNT];
cp_thread_t         m_thread;
issue_rec_t         m_pipe [4];                 // Stage 1 is the one shown on fetch
cp_alu_write_t      m_pending;                  // Accepted write that has not reached memory
int                 retire_count;
int                 taken_count;
int                 cancel_count;
cp_fetch_t          exp_fetch;
cp_instr_t          exp_instr;
logic               exp_known;
logic               exp_jump;
logic               exp_cancel;
cp_pc_t             exp_dest;

task automatic reset_model();
    for (int i = 0; i < `CP_I_DEPTH; i++) begin
        m_known[i] = 1'b0;
    end
    for (int i = 0; i < `CP_BT_DEPTH; i++) begin
        m_bt[i] = '0;
    end
    for (int i = 0; i < `CP_THREAD_COUNT; i++) begin
        m_pc[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
        m_pipe[i] = '0;
    end
    m_thread  = '0;
    m_pending = '0;
endtask

// Expected outputs for the instruction now on fetch, folded against r_prev
task automatic predict_outputs(input cp_alu_word_u r_prev);
    issue_rec_t       f;
    cp_branch_entry_t e;
    logic             hit;
    logic             taken;
    f   = m_pipe[1];
    e   = m_bt[{f.thread, 1'b0}];
    hit = e.enable && (e.origin == f.pc);
    if (!hit) begin  // Slot 1 only counts when slot 0 misses
        e   = m_bt[{f.thread, 1'b1}];
        hit = e.enable && (e.origin == f.pc);
    end
    case (e.condition)
        COND_ALWAYS:   taken = 1'b1;
        COND_ZERO:     taken = (r_prev.raw == '0);
        COND_NONZERO:  taken = (r_prev.raw != '0);
        COND_NEGATIVE: taken = r_prev.raw[`CP_WORD_WIDTH-1];
        COND_POSITIVE: taken = !r_prev.raw[`CP_WORD_WIDTH-1] && (r_prev.raw != '0);
        default:       taken = 1'b0;
    endcase
    exp_fetch  = {f.valid, f.thread, f.pc};
    exp_instr  = f.word;
    exp_known  = f.known;
    exp_jump   = f.valid && hit && taken;
    exp_cancel = exp_jump && e.cancel_on_taken;
    exp_dest   = e.destination;
endtask

// Moves the model across one rising edge with the inputs of the cycle now ending
task automatic advance_model(input cp_alu_write_t w, input logic rdy);
    issue_rec_t             nxt;
    logic [`CP_D_WIDTH-1:0] i_off;
    logic [`CP_D_WIDTH-1:0] bt_off;
    m_pipe[1].retire = rdy | exp_cancel;  // A cancel counts as ready
    m_pipe[1].jump   = exp_jump;
    m_pipe[1].dest   = exp_dest;
    if (m_pipe[1].valid && m_pipe[1].retire) begin
        retire_count++;
    end
    taken_count  += int'(exp_jump);
    cancel_count += int'(exp_cancel);
    nxt        = '0;
    nxt.valid  = 1'b1;
    nxt.thread = m_thread;
    nxt.pc     = m_pc[m_thread];
    nxt.known  = m_known[nxt.pc];  // RAM is read before this edge's write lands
    nxt.word   = m_imem[nxt.pc];
    if (m_pipe[3].valid) begin
        if (m_pipe[3].jump) begin
            m_pc[m_pipe[3].thread] = m_pipe[3].dest;
        end else if (m_pipe[3].retire) begin
            m_pc[m_pipe[3].thread] = m_pipe[3].pc + 1'b1;
        end
    end
    i_off  = m_pending.addr - `CP_I_WRITE_BASE;
    bt_off = m_pending.addr - `CP_BRANCH_WRITE_BASE;
    if (m_pending.en && int'(i_off) < `CP_I_DEPTH) begin
        m_imem[i_off[`CP_PC_WIDTH-1:0]]  = m_pending.data.instr;
        m_known[i_off[`CP_PC_WIDTH-1:0]] = 1'b1;
    end
    if (m_pending.en && int'(bt_off) < `CP_BT_DEPTH) begin
        m_bt[bt_off[`CP_BT_INDEX_WIDTH-1:0]] = m_pending.data.branch;
    end
    m_pending = w;
    m_pipe[3] = m_pipe[2];
    m_pipe[2] = m_pipe[1];
    m_pipe[1] = m_pipe[0];
    m_pipe[0] = nxt;
    m_thread  = m_thread + 1'b1;
endtask

`endif

/* verif/tb_control_path.sv */
`timescale 1ns/100ps
`include "cp_defines.svh"

module tb_control_path
    import cp_isa_pkg::*;
    import cp_thread_pkg::*;
();

    logic           clock;
    logic           rst_n;
    cp_alu_write_t  alu_write;
    logic           io_ready;
    cp_instr_t      instr;
    cp_fetch_t      fetch;
    logic           cancel;

    logic [31:0]    rng_state;
    logic           timed_out;
    int             instr_errors;
    int             fetch_errors;
    int             flag_errors;
    int             other_errors;

    `include "cp_ref_model.svh"

    control_path UUT (
        .clock      (clock),
        .rst_n      (rst_n),
        .alu_write  (alu_write),
        .io_ready   (io_ready),
        .instr      (instr),
        .fetch      (fetch),
        .cancel     (cancel)
    );

    always #4 clock = ~clock;

    // Xorshift32 on the shared generator state
    function automatic logic [31:0] next_rand();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    function automatic cp_alu_word_u rand_word();
        logic [31:0]  hi;
        logic [31:0]  lo;
        cp_alu_word_u w;
        hi    = next_rand();
        lo    = next_rand();
        w.raw = {hi[3:0], lo};
        return w;
    endfunction

    // Results lean toward zero, small and negative values so each condition fires
    function automatic cp_alu_word_u result_word();
        logic [31:0]  r;
        cp_alu_word_u w;
        r = next_rand();
        w = rand_word();
        case (r[1:0])
            2'd0:    w.raw = '0;
            2'd1:    w.raw = {32'h0, r[7:4]};
            2'd2:    w.raw[`CP_WORD_WIDTH-1] = 1'b1;
            default: w.raw = w.raw;
        endcase
        return w;
    endfunction

    // Low origins and destinations keep threads looping where the entries sit
    function automatic cp_alu_word_u make_entry();
        logic [31:0]  r;
        cp_alu_word_u w;
        r = next_rand();
        w = rand_word();
        w.branch.enable          = (r[2:0] != 3'd0);
        w.branch.cancel_on_taken = r[3];
        w.branch.condition       = cp_cond_e'(3'(r[31:8] % 24'd6));
        w.branch.origin          = cp_pc_t'(r[6:4]);
        w.branch.destination     = cp_pc_t'(r[15:12]);
        return w;
    endfunction

    task automatic check_instr(input cp_instr_t got, input cp_instr_t exp);
        if (got !== exp) begin
            instr_errors++;
            $display("FAILED instr got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_fetch(input cp_fetch_t got, input cp_fetch_t exp);
        if (got !== exp) begin
            fetch_errors++;
            $display("FAILED fetch got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Outputs settle after the rising edge, so the model compares on the falling edge
    always @(negedge clock) begin
        if (rst_n) begin
            predict_outputs(alu_write.data);
            check_fetch(fetch, exp_fetch);
            if (exp_fetch.valid && exp_known) begin
                check_instr(instr, exp_instr);
            end
            check_flag("cancel", cancel, exp_cancel);
            advance_model(alu_write, io_ready);
        end
    end

    task automatic wait_first_valid();
        int cycles;
        cycles = 0;
        while (fetch.valid !== 1'b1 && !timed_out) begin
            @(negedge clock);
            cycles++;
            if (cycles > 20) begin
                timed_out = 1'b1;
                $display("Timeout: fetch never became valid after reset");
            end
        end
    endtask

    // Writes count words from base with io_ready held low
    task automatic fill_window(input logic [`CP_D_WIDTH-1:0] base, input int count,
                               input logic branch);
        cp_alu_write_t w;
        for (int i = 0; i < count; i++) begin
            w.en   = 1'b1;
            w.addr = base + 12'(i);
            w.data = branch ? make_entry() : rand_word();
            @(posedge clock);
            alu_write <= w;
            io_ready  <= 1'b0;
        end
    endtask

    task automatic run_traffic(input int retires);
        cp_alu_write_t w;
        logic [31:0]   r;
        int            target;
        int            cycles;
        target = retire_count + retires;
        cycles = 0;
        while (retire_count < target && !timed_out) begin
            r      = next_rand();
            w.en   = 1'b1;
            w.data = result_word();
            case (r[4:2])
                3'd0: w.addr = `CP_I_WRITE_BASE + {2'b00, r[14:5]};
                3'd1: begin
                    w.addr = `CP_BRANCH_WRITE_BASE + {8'h00, r[8:5]};
                    w.data = make_entry();  // Table rewrite in the middle of traffic
                end
                3'd2: w.addr = 12'h400 | {2'b00, r[14:5]};  // Gap between the windows
                default: begin
                    w.en   = 1'b0;
                    w.addr = r[16:5];
                end
            endcase
            @(posedge clock);
            alu_write <= w;
            io_ready  <= (r[1:0] != 2'd0);
            cycles++;
            if (cycles > 20 * retires) begin
                timed_out = 1'b1;
                $display("Timeout: random traffic retired too few instructions");
            end
        end
    endtask

    initial begin
        clock        = 1'b0;
        rst_n        = 1'b0;
        alu_write    = '0;
        io_ready     = 1'b0;
        rng_state    = 32'h1389_925b;
        timed_out    = 1'b0;
        instr_errors = 0;
        fetch_errors = 0;
        flag_errors  = 0;
        other_errors = 0;
        retire_count = 0;
        taken_count  = 0;
        cancel_count = 0;
        reset_model();
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;
        wait_first_valid();
        if (!timed_out) begin
            fill_window(`CP_I_WRITE_BASE, `CP_I_DEPTH, 1'b0);
            fill_window(`CP_BRANCH_WRITE_BASE, `CP_BT_DEPTH, 1'b1);
            run_traffic(800);
        end
        @(posedge clock);
        alu_write <= '0;
        repeat (4) @(posedge clock);
        if (!timed_out && (taken_count == 0 || cancel_count == 0)) begin
            other_errors++;
            $display("No branch was taken or cancelled during the whole run");
        end
        other_errors += int'(timed_out);
        $display("Errors: instr %0d, fetch %0d, flag %0d, other %0d (taken %0d, cancelled %0d)",
                 instr_errors, fetch_errors, flag_errors, other_errors,
                 taken_count, cancel_count);
        if (instr_errors + fetch_errors + flag_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+common
+incdir+verif
common/cp_isa_pkg.sv
common/cp_thread_pkg.sv
design/write_port_decoder.sv
design/instr_mem.sv
branch_folding/branch_folding.sv
design/thread_controller.sv
design/control_path.sv
verif/tb_control_path.sv

/* run_sim.sh */
#!/bin/sh
# Builds the control path testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_control_path \
    -Mdir obj_dir -o tb_control_path
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_control_path > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

# The log decides pass or fail
if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
